// ==== design/pv_consts.svh ====
`ifndef PV_CONSTS_SVH
`define PV_CONSTS_SVH

// Number of PCR entries in the vault
`define PV_NUM_PCR 4

// Dwords held by one PCR entry (384 bits)
`define PV_NUM_DWORDS 12

// Width of one dword on every datapath
`define PV_DATA_W 32

// Dwords in one 1024-bit hash message block
`define PV_BLOCK_DWORDS 32

// Nonce length in dwords (256 bits)
`define PV_NONCE_DWORDS 8

// Dword address width of the vault Wishbone port
`define PV_WB_ADR_W 6

`endif

// ==== design/pv_vault_pkg.sv ====
`include "pv_consts.svh"

package pv_vault_pkg;

  // Hasher read request into the vault, entry plus dword offset
  typedef struct packed {
    logic [$clog2(`PV_NUM_PCR)-1:0]    read_entry;
    logic [$clog2(`PV_NUM_DWORDS)-1:0] read_offset;
  } pv_read_t;

  typedef struct packed {
    logic [`PV_DATA_W-1:0] read_data;
  } pv_rd_resp_t;

  // Wishbone classic request from the bus master
  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [`PV_WB_ADR_W-1:0] adr;
    logic [`PV_DATA_W-1:0]   dat;
  } pv_wb_req_t;

  typedef struct packed {
    logic                  ack;
    logic [`PV_DATA_W-1:0] dat;
  } pv_wb_rsp_t;

endpackage

// ==== design/pv_hash_pkg.sv ====
package pv_hash_pkg;

  // Encodings follow a walk where neighbouring states differ in few bits
  typedef enum logic [3:0] {
    IDLE    = 4'b0000,
    BLOCK_0 = 4'b0001,
    BLOCK_N = 4'b0011,
    NONCE   = 4'b0010,
    PAD_LD1 = 4'b0110,
    PAD_0S  = 4'b0111,
    PAD_LEN = 4'b0101,
    WT_LAST = 4'b0100,
    DONE    = 4'b1100
  } pv_gen_hash_state_e;

  // Command strobes toward the external hash core
  typedef struct packed {
    logic init;
    logic next;
    logic last;
  } pv_core_cmd_t;

endpackage

// ==== design/pv_vault.sv ====
`timescale 1ns/1ps
`include "pv_consts.svh"

module pv_vault (
  input  logic                     clk,
  input  logic                     rst_b,
  input  pv_vault_pkg::pv_wb_req_t wb_req_i,
  output pv_vault_pkg::pv_wb_rsp_t wb_rsp_o,
  input  logic                     busy_i,
  input  pv_vault_pkg::pv_read_t   rd_req_i,
  output pv_vault_pkg::pv_rd_resp_t rd_resp_o
);

  localparam int VAULT_DWORDS = `PV_NUM_PCR * `PV_NUM_DWORDS;

  logic [`PV_DATA_W-1:0]   vault_q [VAULT_DWORDS];
  logic [`PV_DATA_W-1:0]   rdata_q;
  logic                    ack_q;
  logic                    bus_req;
  logic                    adr_valid;
  logic [`PV_WB_ADR_W-1:0] rd_idx;

  // A new bus access is seen once, in the cycle before ack goes out
  assign bus_req   = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign adr_valid = wb_req_i.adr < `PV_WB_ADR_W'(VAULT_DWORDS);

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus_req;
    end
  end

  always_ff @(posedge clk) begin
    if (bus_req) begin
      rdata_q <= adr_valid ? vault_q[wb_req_i.adr] : '0;
    end
  end

  // The generator owns the vault contents while it runs
  always_ff @(posedge clk) begin
    if (bus_req && wb_req_i.we && adr_valid && !busy_i) begin
      vault_q[wb_req_i.adr] <= wb_req_i.dat;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;

  // Flat index is entry times the entry size plus the offset
  assign rd_idx = `PV_WB_ADR_W'(rd_req_i.read_entry) * `PV_WB_ADR_W'(`PV_NUM_DWORDS)
                + `PV_WB_ADR_W'(rd_req_i.read_offset);

  assign rd_resp_o.read_data = vault_q[rd_idx];

endmodule

// ==== design/pv_hash_ptrs.sv ====
`timescale 1ns/1ps
`include "pv_consts.svh"

module pv_hash_ptrs (
  input  logic                   clk,
  input  logic                   rst_b,
  input  logic                   blk_we_i,
  input  logic                   blk_clr_i,
  input  logic                   rd_inc_i,
  input  logic                   rd_clr_i,
  input  logic                   in_nonce_i,
  output logic [5:0]             blk_off_o,
  output logic                   block_full_o,
  output pv_vault_pkg::pv_read_t rd_req_o,
  output logic                   last_pcr_dword_o,
  output logic [2:0]             nonce_off_o
);

  logic [5:0]                        blk_off_q;
  logic [$clog2(`PV_NUM_PCR)-1:0]    entry_q;
  logic [$clog2(`PV_NUM_DWORDS)-1:0] offset_q;
  logic [2:0]                        nonce_off_q;
  logic                              entry_end;

  assign entry_end = offset_q == ($bits(offset_q))'(`PV_NUM_DWORDS - 1);

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      blk_off_q   <= '0;
      entry_q     <= '0;
      offset_q    <= '0;
      nonce_off_q <= '0;
    end else begin
      if (blk_clr_i) begin
        blk_off_q <= '0;
      end else if (blk_we_i) begin
        blk_off_q <= blk_off_q + 6'd1;
      end

      // Clear wins over a step issued in the same cycle
      if (rd_clr_i) begin
        entry_q  <= '0;
        offset_q <= '0;
      end else if (rd_inc_i) begin
        offset_q <= entry_end ? '0 : offset_q + 1'b1;
        if (entry_end) begin
          entry_q <= entry_q + 1'b1;
        end
      end

      if (!in_nonce_i) begin
        nonce_off_q <= '0;
      end else if (blk_we_i) begin
        nonce_off_q <= nonce_off_q + 3'd1;
      end
    end
  end

  assign blk_off_o            = blk_off_q;
  assign block_full_o         = blk_off_q == 6'(`PV_BLOCK_DWORDS);
  assign rd_req_o.read_entry  = entry_q;
  assign rd_req_o.read_offset = offset_q;
  assign last_pcr_dword_o     = entry_end & (entry_q == ($bits(entry_q))'(`PV_NUM_PCR - 1));
  assign nonce_off_o          = nonce_off_q;

endmodule

// ==== design/pv_gen_hash_ctrl.sv ====
`timescale 1ns/1ps
`include "pv_consts.svh"

module pv_gen_hash_ctrl (
  input  logic                                           clk,
  input  logic                                           rst_b,
  input  logic                                           start_i,
  input  logic                                           core_ready_i,
  input  logic                                           core_digest_valid_i,
  input  logic [`PV_NONCE_DWORDS-1:0][`PV_DATA_W-1:0]    nonce_i,
  input  pv_vault_pkg::pv_rd_resp_t                      rd_resp_i,
  input  logic [5:0]                                     blk_off_i,
  input  logic                                           block_full_i,
  input  logic                                           last_pcr_dword_i,
  input  logic [2:0]                                     nonce_off_i,
  output logic                                           blk_we_o,
  output logic                                           blk_clr_o,
  output logic                                           rd_inc_o,
  output logic                                           rd_clr_o,
  output logic                                           in_nonce_o,
  output logic [`PV_DATA_W-1:0]                          wr_data_o,
  output pv_hash_pkg::pv_core_cmd_t                      core_cmd_o,
  output logic                                           busy_o
);

  // Total message length in bits that fills the last four block dwords
  localparam int MSG_BITS = `PV_NUM_PCR * `PV_NUM_DWORDS * `PV_DATA_W
                          + `PV_NONCE_DWORDS * `PV_DATA_W;
  localparam logic [3:0][`PV_DATA_W-1:0] PAD_LENGTH = 128'(MSG_BITS);

  pv_hash_pkg::pv_gen_hash_state_e state_q;
  pv_hash_pkg::pv_gen_hash_state_e state_d;

  logic [2:0]                 nonce_idx;
  logic                       filling;
  logic                       hand_off;

  assign nonce_idx  = 3'(`PV_NONCE_DWORDS - 1) - nonce_off_i;

  assign filling = state_q inside {pv_hash_pkg::BLOCK_0, pv_hash_pkg::BLOCK_N,
                                   pv_hash_pkg::NONCE, pv_hash_pkg::PAD_LD1,
                                   pv_hash_pkg::PAD_0S, pv_hash_pkg::PAD_LEN};

  // A full block leaves for the core only when the core can take it
  assign hand_off = filling & block_full_i & core_ready_i;

  assign busy_o     = state_q != pv_hash_pkg::IDLE;
  assign blk_we_o   = filling & ~block_full_i;
  assign blk_clr_o  = hand_off;
  assign rd_inc_o   = (state_q inside {pv_hash_pkg::BLOCK_0, pv_hash_pkg::BLOCK_N})
                    & ~block_full_i;
  assign rd_clr_o   = (state_q inside {pv_hash_pkg::BLOCK_0, pv_hash_pkg::BLOCK_N})
                    & ~block_full_i & last_pcr_dword_i;
  assign in_nonce_o = state_q == pv_hash_pkg::NONCE;

  assign core_cmd_o.init = hand_off & (state_q == pv_hash_pkg::BLOCK_0);
  assign core_cmd_o.next = hand_off & (state_q != pv_hash_pkg::BLOCK_0);
  assign core_cmd_o.last = state_q == pv_hash_pkg::WT_LAST;

  always_comb begin
    state_d   = state_q;
    wr_data_o = '0;
    case (state_q)
      pv_hash_pkg::IDLE: begin
        if (start_i) begin
          state_d = pv_hash_pkg::BLOCK_0;
        end
      end
      pv_hash_pkg::BLOCK_0, pv_hash_pkg::BLOCK_N: begin
        wr_data_o = rd_resp_i.read_data;
        if (block_full_i) begin
          if (core_ready_i) begin
            state_d = pv_hash_pkg::BLOCK_N;
          end
        end else if (last_pcr_dword_i) begin
          state_d = pv_hash_pkg::NONCE;
        end
      end
      pv_hash_pkg::NONCE: begin
        // Nonce goes in from its highest dword down
        wr_data_o = nonce_i[nonce_idx];
        if (!block_full_i && nonce_off_i == 3'(`PV_NONCE_DWORDS - 1)) begin
          state_d = pv_hash_pkg::PAD_LD1;
        end
      end
      pv_hash_pkg::PAD_LD1: begin
        wr_data_o = 32'h8000_0000;
        if (!block_full_i) begin
          state_d = pv_hash_pkg::PAD_0S;
        end
      end
      pv_hash_pkg::PAD_0S: begin
        if (!block_full_i && blk_off_i == 6'(`PV_BLOCK_DWORDS - 5)) begin
          state_d = pv_hash_pkg::PAD_LEN;
        end
      end
      pv_hash_pkg::PAD_LEN: begin
        // Offsets 28 to 31 pick the length dwords most significant first
        wr_data_o = PAD_LENGTH[2'd3 - blk_off_i[1:0]];
        if (hand_off) begin
          state_d = pv_hash_pkg::WT_LAST;
        end
      end
      pv_hash_pkg::WT_LAST: begin
        if (core_digest_valid_i) begin
          state_d = pv_hash_pkg::DONE;
        end
      end
      pv_hash_pkg::DONE: begin
        state_d = pv_hash_pkg::IDLE;
      end
      default: begin
        state_d = pv_hash_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q <= pv_hash_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== design/pv_block_buf.sv ====
`timescale 1ns/1ps
`include "pv_consts.svh"

module pv_block_buf (
  input  logic                                         clk,
  input  logic                                         rst_b,
  input  logic                                         we_i,
  input  logic [4:0]                                   off_i,
  input  logic [`PV_DATA_W-1:0]                        data_i,
  output logic [`PV_BLOCK_DWORDS-1:0][`PV_DATA_W-1:0]  block_o
);

  logic [`PV_BLOCK_DWORDS-1:0][`PV_DATA_W-1:0] block_q;

  // Dword 0 of the message sits at index 0 of the packed block
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      block_q <= '0;
    end else if (we_i) begin
      block_q[off_i] <= data_i;
    end
  end

  // The core samples the whole block on init or next
  assign block_o = block_q;

endmodule

// ==== design/pv_hash_top.sv ====
`timescale 1ns/1ps
`include "pv_consts.svh"

module pv_hash_top (
  input  logic                                         clk,
  input  logic                                         rst_b,
  input  pv_vault_pkg::pv_wb_req_t                     wb_req_i,
  output pv_vault_pkg::pv_wb_rsp_t                     wb_rsp_o,
  input  logic                                         start_i,
  input  logic [`PV_NONCE_DWORDS-1:0][`PV_DATA_W-1:0]  nonce_i,
  input  logic                                         core_ready_i,
  input  logic                                         core_digest_valid_i,
  output pv_hash_pkg::pv_core_cmd_t                    core_cmd_o,
  output logic [`PV_BLOCK_DWORDS-1:0][`PV_DATA_W-1:0]  block_o,
  output logic                                         busy_o
);

  pv_vault_pkg::pv_read_t    rd_req;
  pv_vault_pkg::pv_rd_resp_t rd_resp;
  logic [5:0]                blk_off;
  logic [2:0]                nonce_off;
  logic [`PV_DATA_W-1:0]     wr_data;
  logic                      blk_we;
  logic                      blk_clr;
  logic                      rd_inc;
  logic                      rd_clr;
  logic                      in_nonce;
  logic                      block_full;
  logic                      last_pcr_dword;

  pv_vault u_vault (
    .clk       (clk),
    .rst_b     (rst_b),
    .wb_req_i  (wb_req_i),
    .wb_rsp_o  (wb_rsp_o),
    .busy_i    (busy_o),
    .rd_req_i  (rd_req),
    .rd_resp_o (rd_resp)
  );

  pv_hash_ptrs u_ptrs (
    .clk              (clk),
    .rst_b            (rst_b),
    .blk_we_i         (blk_we),
    .blk_clr_i        (blk_clr),
    .rd_inc_i         (rd_inc),
    .rd_clr_i         (rd_clr),
    .in_nonce_i       (in_nonce),
    .blk_off_o        (blk_off),
    .block_full_o     (block_full),
    .rd_req_o         (rd_req),
    .last_pcr_dword_o (last_pcr_dword),
    .nonce_off_o      (nonce_off)
  );

  pv_gen_hash_ctrl u_ctrl (
    .clk                 (clk),
    .rst_b               (rst_b),
    .start_i             (start_i),
    .core_ready_i        (core_ready_i),
    .core_digest_valid_i (core_digest_valid_i),
    .nonce_i             (nonce_i),
    .rd_resp_i           (rd_resp),
    .blk_off_i           (blk_off),
    .block_full_i        (block_full),
    .last_pcr_dword_i    (last_pcr_dword),
    .nonce_off_i         (nonce_off),
    .blk_we_o            (blk_we),
    .blk_clr_o           (blk_clr),
    .rd_inc_o            (rd_inc),
    .rd_clr_o            (rd_clr),
    .in_nonce_o          (in_nonce),
    .wr_data_o           (wr_data),
    .core_cmd_o          (core_cmd_o),
    .busy_o              (busy_o)
  );

  // Writes never happen at offset 32, so the low five bits address the buffer
  pv_block_buf u_block_buf (
    .clk     (clk),
    .rst_b   (rst_b),
    .we_i    (blk_we),
    .off_i   (blk_off[4:0]),
    .data_i  (wr_data),
    .block_o (block_o)
  );

endmodule

// ==== verification/pv_hash_tb.sv ====
`timescale 1ns/1ps
`include "pv_consts.svh"

module pv_hash_tb;

  localparam int CLK_PERIOD = 4;
  localparam int NUM_ROWS   = 3;
  localparam int VAULT_DW   = `PV_NUM_PCR * `PV_NUM_DWORDS;
  localparam int MSG_BITS   = VAULT_DW * `PV_DATA_W + `PV_NONCE_DWORDS * `PV_DATA_W;

  // Each run has a vault fill key (0 keeps the vault), a nonce key and the core delays in cycles
  typedef struct packed {
    logic [31:0] fill_key;
    logic [31:0] nonce_key;
    logic [7:0]  ready_delay;
    logic [7:0]  digest_delay;
  } row_t;

  logic clk = 1'b0;
  logic rst_b;
  logic start_i;
  logic core_ready_i = 1'b0;
  logic core_digest_valid_i = 1'b0;
  logic busy_o;
  logic [`PV_NONCE_DWORDS-1:0][`PV_DATA_W-1:0] nonce_i;
  logic [`PV_BLOCK_DWORDS-1:0][`PV_DATA_W-1:0] block_o;
  pv_vault_pkg::pv_wb_req_t  wb_req;
  pv_vault_pkg::pv_wb_rsp_t  wb_rsp;
  pv_hash_pkg::pv_core_cmd_t core_cmd_o;

  row_t        rows [NUM_ROWS];
  logic [31:0] shadow [VAULT_DW];
  logic [31:0] exp_msg [2*`PV_BLOCK_DWORDS];
  logic [31:0] lfsr_q = 32'h102f1507;
  logic [`PV_BLOCK_DWORDS-1:0][`PV_DATA_W-1:0] cap_block [2];
  logic [`PV_BLOCK_DWORDS-1:0][`PV_DATA_W-1:0] held_block;
  logic accepted = 1'b0;
  int ready_delay;
  int digest_delay;
  int init_cnt = 0;
  int next_cnt = 0;
  int last_cnt = 0;
  int last_run = 0;
  int wait_cnt = 0;

  pv_hash_top u_dut (
    .clk                 (clk),
    .rst_b               (rst_b),
    .wb_req_i            (wb_req),
    .wb_rsp_o            (wb_rsp),
    .start_i             (start_i),
    .nonce_i             (nonce_i),
    .core_ready_i        (core_ready_i),
    .core_digest_valid_i (core_digest_valid_i),
    .core_cmd_o          (core_cmd_o),
    .block_o             (block_o),
    .busy_o              (busy_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_eq(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED at %0t: %s expected %h actual %h",
                         $time, name, expected, actual));
    end
  endtask

  task automatic compare_held_block(input string where);
    for (int i = 0; i < `PV_BLOCK_DWORDS; i++) begin
      check_eq($sformatf("%s block_o[%0d]", where, i), block_o[i], held_block[i]);
    end
  endtask

  // Galois LFSR stepped once per bit handed out
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  // Expected message is the PCR dwords, the nonce from its top dword, the 1 marker, zeros, length
  function automatic void build_message();
    logic [127:0] len;
    len = 128'(MSG_BITS);
    for (int i = 0; i < VAULT_DW; i++) begin
      exp_msg[i] = shadow[i];
    end
    for (int i = 0; i < `PV_NONCE_DWORDS; i++) begin
      exp_msg[VAULT_DW + i] = nonce_i[`PV_NONCE_DWORDS - 1 - i];
    end
    exp_msg[56] = 32'h8000_0000;
    for (int i = 57; i < 60; i++) begin
      exp_msg[i] = '0;
    end
    for (int i = 0; i < 4; i++) begin
      exp_msg[60 + i] = len[127 - 32*i -: 32];
    end
  endfunction

  task automatic wb_access(input logic we, input logic [5:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int n;
    n = 0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    do begin
      @(negedge clk);
      n++;
      if (n > 20) begin
        fail_run("Wishbone access got no ack");
      end
    end while (!wb_rsp.ack);
    check_eq("wb_rsp.ack latency in cycles", 32'(n), 32'd1);
    rdat = wb_rsp.dat;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    @(negedge clk);
    check_eq("wb_rsp.ack after one cycle", 32'(wb_rsp.ack), 32'd0);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy_o) begin
      @(negedge clk);
      n++;
      if (n > 600) begin
        fail_run("The generator stayed busy and never returned to idle");
      end
    end
  endtask

  // The core takes the block at the rising edge that closes an init or next pulse
  always @(posedge clk) begin
    if (rst_b && (core_cmd_o.init || core_cmd_o.next)) begin
      check_eq("core_ready_i at pulse", 32'(core_ready_i), 32'd1);
      if (ready_delay >= 40) begin
        compare_held_block("held at pulse");
      end
      if (core_cmd_o.init) begin
        cap_block[0] = block_o;
        init_cnt++;
      end
      if (core_cmd_o.next) begin
        cap_block[1] = block_o;
        next_cnt++;
      end
      accepted = 1'b1;
    end
  end

  // Hash core model moves its own inputs on the falling edge
  always @(negedge clk) begin
    if (!rst_b || !busy_o) begin
      wait_cnt = 0;
      last_run = 0;
      accepted = 1'b0;
      core_ready_i <= 1'b0;
    end else if (accepted) begin
      accepted = 1'b0;
      wait_cnt = 0;
      core_ready_i <= 1'b0;
    end else if (!core_ready_i) begin
      wait_cnt++;
      // A block is full 32 cycles after filling starts, so the snapshot is a full block
      if (wait_cnt == 36) begin
        held_block = block_o;
      end else if (ready_delay >= 40 && wait_cnt > 36) begin
        compare_held_block("held while not ready");
      end
      if (wait_cnt >= ready_delay) begin
        core_ready_i <= 1'b1;
      end
    end
    if (core_digest_valid_i) begin
      core_digest_valid_i <= 1'b0;
    end else if (busy_o && core_cmd_o.last) begin
      last_cnt++;
      last_run++;
      if (last_run >= digest_delay) begin
        core_digest_valid_i <= 1'b1;
      end
    end
  end

  initial begin
    #(NUM_ROWS * 400 * CLK_PERIOD);
    fail_run("Watchdog expired before all table rows finished");
  end

  initial begin
    logic [31:0] rd;
    logic [5:0]  busy_adr;
    int          last_total;
    rst_b      = 1'b0;
    start_i    = 1'b0;
    nonce_i    = '0;
    wb_req     = '0;
    last_total = 0;
    rows[0] = '{32'h1f2e_3d4c, 32'h5a5a_0001, 8'd45, 8'd3};
    rows[1] = '{32'h0000_0000, 32'h0000_beef, 8'd2, 8'd1};
    rows[2] = '{32'hc3c3_77e1, 32'h1234_5678, 8'd60, 8'd7};
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_b = 1'b1;
    check_eq("busy_o after reset", 32'(busy_o), 32'd0);
    check_eq("core_cmd_o after reset", 32'(core_cmd_o), 32'd0);
    check_eq("wb_rsp.ack after reset", 32'(wb_rsp.ack), 32'd0);

    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].fill_key != 0) begin
        for (int a = 0; a < VAULT_DW; a++) begin
          shadow[a] = rand_word() ^ rows[r].fill_key;
          wb_access(1'b1, 6'(a), shadow[a], rd);
        end
      end
      for (int a = 0; a < VAULT_DW; a++) begin
        wb_access(1'b0, 6'(a), 32'd0, rd);
        check_eq($sformatf("vault[%0d] readback", a), rd, shadow[a]);
      end
      for (int i = 0; i < `PV_NONCE_DWORDS; i++) begin
        nonce_i[i] = rand_word() ^ rows[r].nonce_key;
      end
      ready_delay  = int'(rows[r].ready_delay);
      digest_delay = int'(rows[r].digest_delay);
      build_message();

      start_i = 1'b1;
      @(negedge clk);
      start_i = 1'b0;
      check_eq("busy_o after start", 32'(busy_o), 32'd1);
      // This write lands while busy and must leave the vault as it was
      busy_adr = 6'(r * 7 + 5);
      wb_access(1'b1, busy_adr, ~shadow[busy_adr], rd);
      start_i = 1'b1;
      @(negedge clk);
      start_i = 1'b0;
      wait_idle();

      last_total += digest_delay;
      check_eq("init pulse count", 32'(init_cnt), 32'(r + 1));
      check_eq("next pulse count", 32'(next_cnt), 32'(r + 1));
      check_eq("last high cycles", 32'(last_cnt), 32'(last_total));
      for (int i = 0; i < `PV_BLOCK_DWORDS; i++) begin
        check_eq($sformatf("init block_o[%0d]", i), cap_block[0][i], exp_msg[i]);
        check_eq($sformatf("next block_o[%0d]", i), cap_block[1][i], exp_msg[32 + i]);
      end
      wb_access(1'b0, busy_adr, 32'd0, rd);
      check_eq("vault after busy write", rd, shadow[busy_adr]);
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+design
design/pv_vault_pkg.sv
design/pv_hash_pkg.sv
design/pv_vault.sv
design/pv_hash_ptrs.sv
design/pv_gen_hash_ctrl.sv
design/pv_block_buf.sv
design/pv_hash_top.sv
verification/pv_hash_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status follows the result

cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f verilog.f \
  --top-module pv_hash_tb -o pv_hash_sim &&
./obj_dir/pv_hash_sim | grep -q "Result: PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
